// File: sdram_map_pkg.sv
`default_nettype none

package sdram_map_pkg;

    // SDRAM side
    typedef logic [21:0] sdram_addr_t;
    typedef logic [31:0] sdram_word_t;
    typedef logic [15:0] half_word_t;
    typedef logic [1:0]  bank_t;
    // Active low, bit 1 is the upper byte
    typedef logic [1:0]  wrmask_t;

    // Requester address spaces, all word addresses except sound
    typedef logic [20:0] rom_addr_t;
    typedef logic [16:0] ram_addr_t;
    typedef logic [21:0] gfx_addr_t;
    typedef logic [15:0] snd_addr_t;
    typedef logic [7:0]  snd_byte_t;

    // Region offsets inside the SDRAM word space
    localparam sdram_addr_t SOUND_OFFSET_DEF = 22'h00_0000;
    localparam sdram_addr_t RAM_OFFSET_DEF   = 22'h20_0000;
    localparam sdram_addr_t VRAM_OFFSET_DEF  = 22'h30_0000;
    // Graphics sit alone in their bank
    localparam sdram_addr_t GFX_OFFSET_DEF   = 22'h00_0000;

    // Bank codes
    localparam bank_t BANK_SOUND = 2'd0;
    localparam bank_t BANK_CPU   = 2'd1;
    localparam bank_t BANK_GFX   = 2'd2;

endpackage

`default_nettype wire

// File: slot_bus_pkg.sv
`default_nettype none

package slot_bus_pkg;

    // ROM, RAM/VRAM, graphics, sound
    localparam int NUM_SLOTS = 4;

    typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;
    typedef logic [NUM_SLOTS-1:0]         slot_vec_t;

    // Access sequence of the arbiter
    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_DATA
    } arb_state_t;

endpackage

`default_nettype wire

// File: slot_bus_if.sv
`default_nettype none

interface slot_bus_if;

    // Single cycle, access handed to a slot
    logic                    grant;
    // Granted slot, held until the next grant
    slot_bus_pkg::slot_idx_t sel;
    // Single cycle, read data valid for sel
    logic                    done;
    // Per slot completion level
    slot_bus_pkg::slot_vec_t ok;

    modport ctrl (
        output grant,
        output sel,
        output done,
        input  ok
    );

    modport dp (
        input  grant,
        input  sel,
        input  done,
        output ok
    );

endinterface

`default_nettype wire

// File: slot_arbiter.sv
`default_nettype none

module slot_arbiter (
    input  logic                    VB,
    input  logic                    rst_n,
    input  logic                    downloading,
    input  slot_bus_pkg::slot_vec_t cs,
    output logic                    sdram_req,
    input  logic                    sdram_ack,
    input  logic                    data_rdy,
    slot_bus_if.ctrl                bus
);

    slot_bus_pkg::arb_state_t state;
    slot_bus_pkg::slot_vec_t  pending;
    slot_bus_pkg::slot_idx_t  pick;
    slot_bus_pkg::slot_idx_t  sel_q;

    // Lowest set bit wins
    function automatic slot_bus_pkg::slot_idx_t first_set(
        input slot_bus_pkg::slot_vec_t vec
    );
        slot_bus_pkg::slot_idx_t idx;
        idx = '0;
        for (int i = slot_bus_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = slot_bus_pkg::slot_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // A slot that already holds ok is served until it drops cs
    assign pending = cs & ~bus.ok;
    assign pick    = first_set(pending);

    assign bus.grant = (state == slot_bus_pkg::IDLE) && !downloading && (|pending);
    assign bus.sel   = bus.grant ? pick : sel_q;
    assign bus.done  = (state == slot_bus_pkg::WAIT_DATA) && data_rdy;

    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            state     <= slot_bus_pkg::IDLE;
            sdram_req <= 1'b0;
            sel_q     <= '0;
        end else begin
            case (state)
                slot_bus_pkg::IDLE: begin
                    if (bus.grant) begin
                        sel_q     <= pick;
                        sdram_req <= 1'b1;
                        state     <= slot_bus_pkg::REQ;
                    end
                end
                slot_bus_pkg::REQ: begin
                    // Request held as a level until the controller takes it
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= slot_bus_pkg::WAIT_DATA;
                    end
                end
                slot_bus_pkg::WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= slot_bus_pkg::IDLE;
                    end
                end
                default: begin
                    sdram_req <= 1'b0;
                    state     <= slot_bus_pkg::IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: slot_addr_map.sv
`default_nettype none

module slot_addr_map #(
    parameter sdram_map_pkg::sdram_addr_t SOUND_OFFSET = sdram_map_pkg::SOUND_OFFSET_DEF,
    parameter sdram_map_pkg::sdram_addr_t RAM_OFFSET   = sdram_map_pkg::RAM_OFFSET_DEF,
    parameter sdram_map_pkg::sdram_addr_t VRAM_OFFSET  = sdram_map_pkg::VRAM_OFFSET_DEF,
    parameter sdram_map_pkg::sdram_addr_t GFX_OFFSET   = sdram_map_pkg::GFX_OFFSET_DEF
) (
    input  logic                       VB,
    input  logic                       rst_n,
    input  sdram_map_pkg::rom_addr_t   rom_addr,
    input  sdram_map_pkg::ram_addr_t   ram_addr,
    input  logic                       vram_cs,
    input  logic                       ram_we,
    input  sdram_map_pkg::wrmask_t     ram_dsn,
    input  sdram_map_pkg::half_word_t  ram_din,
    input  sdram_map_pkg::gfx_addr_t   gfx_addr,
    input  sdram_map_pkg::snd_addr_t   snd_addr,
    slot_bus_if.dp                     bus,
    output sdram_map_pkg::sdram_addr_t sdram_addr,
    output sdram_map_pkg::bank_t       sdram_bank,
    output logic                       sdram_rnw,
    output sdram_map_pkg::wrmask_t     sdram_wrmask,
    output sdram_map_pkg::half_word_t  data_write
);

    // Bank and direction
    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            sdram_bank   <= sdram_map_pkg::BANK_SOUND;
            sdram_rnw    <= 1'b1;
            sdram_wrmask <= 2'b11;
        end else if (bus.grant) begin
            sdram_rnw    <= 1'b1;
            sdram_wrmask <= 2'b11;
            case (bus.sel)
                2'd0: sdram_bank <= sdram_map_pkg::BANK_CPU;
                2'd1: begin
                    // Only the RAM slot can write
                    sdram_bank   <= sdram_map_pkg::BANK_CPU;
                    sdram_rnw    <= ~ram_we;
                    sdram_wrmask <= ram_we ? ram_dsn : 2'b11;
                end
                2'd2: sdram_bank <= sdram_map_pkg::BANK_GFX;
                default: sdram_bank <= sdram_map_pkg::BANK_SOUND;
            endcase
        end
    end

    // Address and write data
    always_ff @(posedge VB) begin
        if (bus.grant) begin
            data_write <= ram_din;
            case (bus.sel)
                2'd0: sdram_addr <= sdram_map_pkg::sdram_addr_t'(rom_addr);
                2'd1: sdram_addr <= (vram_cs ? VRAM_OFFSET : RAM_OFFSET)
                                    + sdram_map_pkg::sdram_addr_t'(ram_addr);
                2'd2: sdram_addr <= GFX_OFFSET + gfx_addr;
                // Sound is byte addressed, one SDRAM word holds two bytes
                default: sdram_addr <= SOUND_OFFSET
                                       + sdram_map_pkg::sdram_addr_t'(snd_addr >> 1);
            endcase
        end
    end

endmodule

`default_nettype wire

// File: slot_data_return.sv
`default_nettype none

module slot_data_return (
    input  logic                       VB,
    input  logic                       rst_n,
    input  slot_bus_pkg::slot_vec_t    cs,
    input  sdram_map_pkg::snd_addr_t   snd_addr,
    input  sdram_map_pkg::sdram_word_t data_read,
    slot_bus_if.dp                     bus,
    output sdram_map_pkg::half_word_t  rom_data,
    output sdram_map_pkg::half_word_t  ram_data,
    output sdram_map_pkg::sdram_word_t gfx_data,
    output sdram_map_pkg::snd_byte_t   snd_data
);

    slot_bus_pkg::slot_vec_t ok_q;
    slot_bus_pkg::slot_vec_t ok_set;

    // One hot of the finished slot
    assign ok_set = bus.done ? (slot_bus_pkg::slot_vec_t'(1) << bus.sel) : '0;

    assign bus.ok = ok_q;

    // Set on completion, cleared as soon as cs is gone
    always_ff @(posedge VB or negedge rst_n) begin
        if (!rst_n) begin
            ok_q <= '0;
        end else begin
            ok_q <= (ok_q | ok_set) & cs;
        end
    end

    // Data registers hold their value until the next access of the slot
    always_ff @(posedge VB) begin
        if (bus.done) begin
            case (bus.sel)
                2'd0: rom_data <= data_read[15:0];
                2'd1: ram_data <= data_read[15:0];
                2'd2: gfx_data <= data_read;
                default: begin
                    // Odd byte address is the upper byte
                    if (snd_addr[0]) begin
                        snd_data <= data_read[15:8];
                    end else begin
                        snd_data <= data_read[7:0];
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sdram_slot_mux.sv
`default_nettype none

module sdram_slot_mux #(
    parameter sdram_map_pkg::sdram_addr_t SOUND_OFFSET = sdram_map_pkg::SOUND_OFFSET_DEF,
    parameter sdram_map_pkg::sdram_addr_t RAM_OFFSET   = sdram_map_pkg::RAM_OFFSET_DEF,
    parameter sdram_map_pkg::sdram_addr_t VRAM_OFFSET  = sdram_map_pkg::VRAM_OFFSET_DEF,
    parameter sdram_map_pkg::sdram_addr_t GFX_OFFSET   = sdram_map_pkg::GFX_OFFSET_DEF
) (
    input  logic                       VB,
    input  logic                       rst_n,
    input  logic                       downloading,
    // Main CPU ROM
    input  logic                       rom_cs,
    input  sdram_map_pkg::rom_addr_t   rom_addr,
    output sdram_map_pkg::half_word_t  rom_data,
    output logic                       rom_ok,
    // Main RAM and VRAM
    input  logic                       ram_cs,
    input  logic                       vram_cs,
    input  sdram_map_pkg::ram_addr_t   ram_addr,
    input  logic                       ram_we,
    input  sdram_map_pkg::wrmask_t     ram_dsn,
    input  sdram_map_pkg::half_word_t  ram_din,
    output sdram_map_pkg::half_word_t  ram_data,
    output logic                       ram_ok,
    // Graphics ROM
    input  logic                       gfx_cs,
    input  sdram_map_pkg::gfx_addr_t   gfx_addr,
    output sdram_map_pkg::sdram_word_t gfx_data,
    output logic                       gfx_ok,
    // Sound ROM
    input  logic                       snd_cs,
    input  sdram_map_pkg::snd_addr_t   snd_addr,
    output sdram_map_pkg::snd_byte_t   snd_data,
    output logic                       snd_ok,
    // SDRAM controller
    input  logic                       sdram_ack,
    input  logic                       data_rdy,
    input  sdram_map_pkg::sdram_word_t data_read,
    output logic                       sdram_req,
    output sdram_map_pkg::sdram_addr_t sdram_addr,
    output sdram_map_pkg::bank_t       sdram_bank,
    output logic                       sdram_rnw,
    output sdram_map_pkg::wrmask_t     sdram_wrmask,
    output sdram_map_pkg::half_word_t  data_write
);

    slot_bus_pkg::slot_vec_t slot_cs;

    slot_bus_if bus ();

    // RAM and VRAM share slot 1
    assign slot_cs = {snd_cs, gfx_cs, ram_cs | vram_cs, rom_cs};

    assign rom_ok = bus.ok[0];
    assign ram_ok = bus.ok[1];
    assign gfx_ok = bus.ok[2];
    assign snd_ok = bus.ok[3];

    slot_arbiter u_arbiter (
        .VB          (VB),
        .rst_n       (rst_n),
        .downloading (downloading),
        .cs          (slot_cs),
        .sdram_req   (sdram_req),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .bus         (bus.ctrl)
    );

    slot_addr_map #(
        .SOUND_OFFSET (SOUND_OFFSET),
        .RAM_OFFSET   (RAM_OFFSET),
        .VRAM_OFFSET  (VRAM_OFFSET),
        .GFX_OFFSET   (GFX_OFFSET)
    ) u_addr_map (
        .VB           (VB),
        .rst_n        (rst_n),
        .rom_addr     (rom_addr),
        .ram_addr     (ram_addr),
        .vram_cs      (vram_cs),
        .ram_we       (ram_we),
        .ram_dsn      (ram_dsn),
        .ram_din      (ram_din),
        .gfx_addr     (gfx_addr),
        .snd_addr     (snd_addr),
        .bus          (bus.dp),
        .sdram_addr   (sdram_addr),
        .sdram_bank   (sdram_bank),
        .sdram_rnw    (sdram_rnw),
        .sdram_wrmask (sdram_wrmask),
        .data_write   (data_write)
    );

    slot_data_return u_data_return (
        .VB        (VB),
        .rst_n     (rst_n),
        .cs        (slot_cs),
        .snd_addr  (snd_addr),
        .data_read (data_read),
        .bus       (bus.dp),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .gfx_data  (gfx_data),
        .snd_data  (snd_data)
    );

endmodule

`default_nettype wire

// File: tb_sdram_model.sv
`default_nettype none

module tb_sdram_model (
    input  logic                       VB,
    input  logic                       rst_n,
    input  int unsigned                ack_dly,
    input  int unsigned                rdy_dly,
    input  logic                       sdram_req,
    input  sdram_map_pkg::sdram_addr_t sdram_addr,
    input  sdram_map_pkg::bank_t       sdram_bank,
    input  logic                       sdram_rnw,
    input  sdram_map_pkg::wrmask_t     sdram_wrmask,
    input  sdram_map_pkg::half_word_t  data_write,
    output logic                       sdram_ack,
    output logic                       data_rdy,
    output sdram_map_pkg::sdram_word_t data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    // Written words, keyed by bank and word address
    sdram_map_pkg::sdram_word_t mem [logic [23:0]];

    // Unwritten words read as a pattern of the whole address
    function automatic sdram_map_pkg::sdram_word_t fill_word(input logic [23:0] key);
        return {key[7:0] ^ 8'h3c, key ^ 24'h5a_c3a5};
    endfunction

    // Resumes 1 ns after the edge
    task automatic skip_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge VB);
            #1;
        end
    endtask

    initial begin
        logic [23:0]                key;
        sdram_map_pkg::sdram_word_t word;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            skip_cycles(1);
            if (rst_n && sdram_req) begin
                skip_cycles(ack_dly);
                key  = {sdram_bank, sdram_addr};
                word = mem.exists(key) ? mem[key] : fill_word(key);
                // Active-low byte mask, bit 1 is the upper byte
                if (!sdram_rnw) begin
                    if (!sdram_wrmask[0]) begin
                        word[7:0] = data_write[7:0];
                    end
                    if (!sdram_wrmask[1]) begin
                        word[15:8] = data_write[15:8];
                    end
                    mem[key] = word;
                end
                sdram_ack = 1'b1;
                skip_cycles(1);
                sdram_ack = 1'b0;
                skip_cycles(rdy_dly);
                data_rdy  = 1'b1;
                data_read = word;
                skip_cycles(1);
                data_rdy  = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_sdram_slot_mux.sv
`default_nettype none

module tb_sdram_slot_mux;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT      = 100;
    localparam int BLOCK_CYCLES = 20;
    localparam int MIX_COUNT    = 300;
    // Offsets away from the package defaults
    localparam sdram_map_pkg::sdram_addr_t SND_OFS  = 22'h01_0000;
    localparam sdram_map_pkg::sdram_addr_t RAM_OFS  = 22'h28_0000;
    localparam sdram_map_pkg::sdram_addr_t VRAM_OFS = 22'h38_0000;
    localparam sdram_map_pkg::sdram_addr_t GFX_OFS  = 22'h04_0000;

    typedef struct packed {
        sdram_map_pkg::sdram_addr_t addr;
        sdram_map_pkg::bank_t       bank;
        logic                       rnw;
        sdram_map_pkg::wrmask_t     mask;
        sdram_map_pkg::half_word_t  wdata;
    } req_fields_t;

    logic                       VB;
    logic                       rst_n;
    logic                       downloading;
    logic                       rom_cs;
    sdram_map_pkg::rom_addr_t   rom_addr;
    sdram_map_pkg::half_word_t  rom_data;
    logic                       rom_ok;
    logic                       ram_cs;
    logic                       vram_cs;
    sdram_map_pkg::ram_addr_t   ram_addr;
    logic                       ram_we;
    sdram_map_pkg::wrmask_t     ram_dsn;
    sdram_map_pkg::half_word_t  ram_din;
    sdram_map_pkg::half_word_t  ram_data;
    logic                       ram_ok;
    logic                       gfx_cs;
    sdram_map_pkg::gfx_addr_t   gfx_addr;
    sdram_map_pkg::sdram_word_t gfx_data;
    logic                       gfx_ok;
    logic                       snd_cs;
    sdram_map_pkg::snd_addr_t   snd_addr;
    sdram_map_pkg::snd_byte_t   snd_data;
    logic                       snd_ok;
    logic                       sdram_ack;
    logic                       data_rdy;
    sdram_map_pkg::sdram_word_t data_read;
    logic                       sdram_req;
    sdram_map_pkg::sdram_addr_t sdram_addr;
    sdram_map_pkg::bank_t       sdram_bank;
    logic                       sdram_rnw;
    sdram_map_pkg::wrmask_t     sdram_wrmask;
    sdram_map_pkg::half_word_t  data_write;
    int unsigned                ack_dly;
    int unsigned                rdy_dly;

    logic [3:0]                 ok_bits;
    logic [3:0]                 cs_bits;
    logic                       ack_prev = 1'b0;
    logic                       slot1_vram;
    sdram_map_pkg::sdram_addr_t exp_addr [4];
    sdram_map_pkg::bank_t       exp_bank [4];
    logic [31:0]                exp_data [4];
    logic                       exp_rnw [4];
    logic [1:0]                 exp_mask [4];
    logic [15:0]                exp_wdata [4];
    req_fields_t                cap_q [$];
    logic [31:0]                shadow [logic [23:0]];
    int                         errors = 0;
    int                         checks = 0;
    string data_name [4] = '{"rom_data", "ram_data", "gfx_data", "snd_data"};

    assign ok_bits = {snd_ok, gfx_ok, ram_ok, rom_ok};
    assign cs_bits = {snd_cs, gfx_cs, ram_cs | vram_cs, rom_cs};

    sdram_slot_mux #(
        .SOUND_OFFSET (SND_OFS),
        .RAM_OFFSET   (RAM_OFS),
        .VRAM_OFFSET  (VRAM_OFS),
        .GFX_OFFSET   (GFX_OFS)
    ) i_sdram_slot_mux (.*);

    tb_sdram_model sdram_model (.*);

    initial begin
        VB = 1'b0;
        forever begin
            #4 VB = ~VB;
        end
    end

    // Word that the controller holds when nothing was written there
    function automatic logic [31:0] pattern_word(input logic [23:0] key);
        return {key[7:0] ^ 8'h3c, key ^ 24'h5a_c3a5};
    endfunction

    // Expected SDRAM address, bank and slot data from the memory map
    function automatic void ref_access(
        input  int                         slot,
        input  logic [21:0]                a,
        input  logic                       vram,
        input  logic                       we,
        input  logic [1:0]                 dsn,
        input  logic [15:0]                din,
        output sdram_map_pkg::sdram_addr_t e_addr,
        output sdram_map_pkg::bank_t       e_bank,
        output logic [31:0]                e_data
    );
        logic [23:0] key;
        logic [31:0] word;
        case (slot)
            0: begin
                e_addr = {1'b0, a[20:0]};
                e_bank = sdram_map_pkg::BANK_CPU;
            end
            1: begin
                e_addr = (vram ? VRAM_OFS : RAM_OFS) + {5'b0, a[16:0]};
                e_bank = sdram_map_pkg::BANK_CPU;
            end
            2: begin
                e_addr = GFX_OFS + a;
                e_bank = sdram_map_pkg::BANK_GFX;
            end
            default: begin
                e_addr = SND_OFS + {7'b0, a[15:1]};
                e_bank = sdram_map_pkg::BANK_SOUND;
            end
        endcase
        key  = {e_bank, e_addr};
        word = shadow.exists(key) ? shadow[key] : pattern_word(key);
        // Writes update the shadow memory
        if (we) begin
            if (!dsn[0]) begin
                word[7:0] = din[7:0];
            end
            if (!dsn[1]) begin
                word[15:8] = din[15:8];
            end
            shadow[key] = word;
        end
        case (slot)
            0, 1: e_data = {16'h0, word[15:0]};
            2: e_data = word;
            default: e_data = {24'h0, (a[0] ? word[15:8] : word[7:0])};
        endcase
    endfunction

    function automatic logic [31:0] slot_data(input int slot);
        case (slot)
            0: return {16'h0, rom_data};
            1: return {16'h0, ram_data};
            2: return gfx_data;
            default: return {24'h0, snd_data};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expv,
                               input logic [31:0] got);
        checks++;
        assert (got === expv) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, expv, got);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge VB);
        #1;
    endtask

    // Sets one slot's request inputs and its expected results
    task automatic load_slot(input int slot, input logic [21:0] a, input logic vram,
                             input logic we, input logic [1:0] dsn, input logic [15:0] din);
        sdram_map_pkg::sdram_addr_t e_addr;
        sdram_map_pkg::bank_t       e_bank;
        logic [31:0]                e_data;
        ref_access(slot, a, vram, we, dsn, din, e_addr, e_bank, e_data);
        exp_addr[slot]  = e_addr;
        exp_bank[slot]  = e_bank;
        exp_data[slot]  = e_data;
        exp_rnw[slot]   = !we;
        exp_mask[slot]  = we ? dsn : 2'b11;
        exp_wdata[slot] = din;
        case (slot)
            0: rom_addr = a[20:0];
            1: begin
                ram_addr   = a[16:0];
                slot1_vram = vram;
                ram_we     = we;
                ram_dsn    = dsn;
                ram_din    = din;
            end
            2: gfx_addr = a;
            default: snd_addr = a[15:0];
        endcase
    endtask

    task automatic drive_cs(input logic [3:0] mask);
        ack_dly = $urandom_range(5);
        rdy_dly = $urandom_range(5);
        rom_cs  = mask[0];
        ram_cs  = mask[1] && !slot1_vram;
        vram_cs = mask[1] && slot1_vram;
        gfx_cs  = mask[2];
        snd_cs  = mask[3];
    endtask

    // Compares the request fields and the data of one finished slot
    task automatic check_slot(input int slot);
        req_fields_t f;
        assert (cap_q.size() == 1) else begin
            $display("Error at %0t: %0d SDRAM requests seen for one completion of slot %0d",
                     $time, cap_q.size(), slot);
            errors++;
        end
        check_value(data_name[slot], exp_data[slot], slot_data(slot));
        if (cap_q.size() > 0) begin
            f = cap_q.pop_front();
            check_value("sdram_addr", exp_addr[slot], f.addr);
            check_value("sdram_bank", exp_bank[slot], f.bank);
            check_value("sdram_rnw", exp_rnw[slot], f.rnw);
            check_value("sdram_wrmask", exp_mask[slot], f.mask);
            if (!exp_rnw[slot]) begin
                check_value("data_write", exp_wdata[slot], f.wdata);
            end
        end
    endtask

    task automatic await_oks(input logic [3:0] mask);
        logic [3:0] seen;
        logic [3:0] fresh;
        logic [3:0] next_bit;
        int         n;
        seen = 4'h0;
        n    = 0;
        while (seen != mask && n < TIMEOUT) begin
            @(negedge VB);
            n++;
            fresh    = ok_bits & mask & ~seen;
            // Lowest slot still waiting is served next
            next_bit = 4'h0;
            for (int i = 0; i < 4; i++) begin
                if (mask[i] && !seen[i] && next_bit == 4'h0) begin
                    next_bit = 4'h1 << i;
                end
            end
            if (fresh != 4'h0) begin
                assert (fresh == next_bit) else begin
                    $display("FAIL t=%0t {snd_ok, gfx_ok, ram_ok, rom_ok} expected %b got %b",
                             $time, seen | next_bit, ok_bits);
                    errors++;
                end
                for (int i = 0; i < 4; i++) begin
                    if (fresh[i]) begin
                        check_slot(i);
                    end
                end
                seen = seen | fresh;
            end
            assert ((seen & ~ok_bits) == 4'h0) else begin
                $display("Error at %0t: an ok fell while its cs was still high", $time);
                errors++;
            end
            assert ((ok_bits & ~mask) == 4'h0) else begin
                $display("Error at %0t: an ok rose on a slot without cs", $time);
                errors++;
            end
        end
        assert (seen == mask) else begin
            $display("Timeout at %0t: ok never rose for slots %b", $time, mask & ~seen);
            errors++;
        end
    endtask

    task automatic release_cs(input logic [3:0] mask);
        next_cycle();
        rom_cs  = 1'b0;
        ram_cs  = 1'b0;
        vram_cs = 1'b0;
        gfx_cs  = 1'b0;
        snd_cs  = 1'b0;
        @(negedge VB);
        check_value("{snd_ok, gfx_ok, ram_ok, rom_ok}", 32'(mask), 32'(ok_bits));
        @(negedge VB);
        check_value("{snd_ok, gfx_ok, ram_ok, rom_ok}", 32'h0, 32'(ok_bits));
    endtask

    task automatic serve(input logic [3:0] mask);
        next_cycle();
        drive_cs(mask);
        await_oks(mask);
        release_cs(mask);
    endtask

    // Request fields captured at ack, bus rules checked every cycle
    always @(negedge VB) begin
        req_fields_t cap;
        if (rst_n) begin
            assert (!sdram_req || (cs_bits & ~ok_bits) != 4'h0) else begin
                $display("Error at %0t: sdram_req high with no access in progress", $time);
                errors++;
            end
            assert (!(sdram_req && ack_prev)) else begin
                $display("Error at %0t: sdram_req still high after sdram_ack", $time);
                errors++;
            end
            if (sdram_req && sdram_ack) begin
                cap.addr  = sdram_addr;
                cap.bank  = sdram_bank;
                cap.rnw   = sdram_rnw;
                cap.mask  = sdram_wrmask;
                cap.wdata = data_write;
                cap_q.push_back(cap);
            end
        end
        ack_prev = sdram_req && sdram_ack;
    end

    initial begin
        logic [21:0] a;
        logic [3:0]  mask;
        logic        v;
        void'($urandom(32'hc059_80b8));
        rst_n       = 1'b0;
        downloading = 1'b0;
        rom_cs      = 1'b0;
        rom_addr    = '0;
        ram_cs      = 1'b0;
        vram_cs     = 1'b0;
        ram_addr    = '0;
        ram_we      = 1'b0;
        ram_dsn     = 2'b11;
        ram_din     = '0;
        gfx_cs      = 1'b0;
        gfx_addr    = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        ack_dly     = 0;
        rdy_dly     = 0;
        slot1_vram  = 1'b0;
        repeat (2) @(posedge VB);
        #1;
        rst_n = 1'b1;
        @(negedge VB);
        assert (!sdram_req && ok_bits == 4'h0) else begin
            $display("Error at %0t: sdram_req or an ok is high after reset", $time);
            errors++;
        end

        // Each slot alone
        for (int s = 0; s < 3; s++) begin
            load_slot(s, 22'($urandom), 1'b0, 1'b0, 2'b11, 16'h0);
            serve(4'h1 << s);
        end
        // Both bytes of one sound word
        a = 22'($urandom);
        for (int b = 0; b < 2; b++) begin
            load_slot(3, {a[21:1], 1'(b)}, 1'b0, 1'b0, 2'b11, 16'h0);
            serve(4'h8);
        end

        // RAM and VRAM at the same slot address, every write mask
        for (int m = 0; m < 4; m++) begin
            a = 22'($urandom_range(255));
            for (int vv = 0; vv < 2; vv++) begin
                load_slot(1, a, 1'(vv), 1'b1, 2'(m), 16'($urandom));
                serve(4'h2);
            end
            for (int vv = 0; vv < 2; vv++) begin
                load_slot(1, a, 1'(vv), 1'b0, 2'b11, 16'h0);
                serve(4'h2);
            end
        end

        // All four at once
        for (int s = 0; s < 4; s++) begin
            load_slot(s, 22'($urandom), 1'b0, 1'b0, 2'b11, 16'h0);
        end
        serve(4'hf);

        // Held off while downloading
        load_slot(2, 22'($urandom), 1'b0, 1'b0, 2'b11, 16'h0);
        next_cycle();
        downloading = 1'b1;
        drive_cs(4'h4);
        for (int n = 0; n < BLOCK_CYCLES; n++) begin
            @(negedge VB);
            assert (!sdram_req && ok_bits == 4'h0) else begin
                $display("Error at %0t: access started while downloading", $time);
                errors++;
            end
        end
        next_cycle();
        downloading = 1'b0;
        await_oks(4'h4);
        release_cs(4'h4);

        // Random mix, RAM kept to a few words so reads hit earlier writes
        for (int k = 0; k < MIX_COUNT; k++) begin
            mask = 4'($urandom_range(15, 1));
            v    = 1'($urandom);
            for (int s = 0; s < 4; s++) begin
                if (mask[s]) begin
                    a = (s == 1) ? 22'($urandom_range(31)) : 22'($urandom);
                    load_slot(s, a, v, (s == 1) && 1'($urandom), 2'($urandom),
                              16'($urandom));
                end
            end
            serve(mask);
        end

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
sdram_map_pkg.sv
slot_bus_pkg.sv
slot_bus_if.sv
slot_arbiter.sv
slot_addr_map.sv
slot_data_return.sv
sdram_slot_mux.sv
tb_sdram_model.sv
tb_sdram_slot_mux.sv

// File: Bender.yml
package:
  name: sdram_slot_mux

sources:
  - sdram_map_pkg.sv
  - slot_bus_pkg.sv
  - slot_bus_if.sv
  - slot_arbiter.sv
  - slot_addr_map.sv
  - slot_data_return.sv
  - sdram_slot_mux.sv
  - target: test
    files:
      - tb_sdram_model.sv
      - tb_sdram_slot_mux.sv
